//--- aud_core_top.f
hw/aud_pkg.sv
hw/sample_mem.sv
hw/aud_recorder.sv
hw/aud_player.sv
hw/aud_ctrl_regs.sv
hw/aud_core_top.sv
test/aud_checker.sv
test/tb_aud_core_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_aud_core_top
FILELIST  ?= aud_core_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o sim_$(TOP)
	$(BUILD_DIR)/sim_$(TOP) | tee $(LOG)
	grep -q "^Result: PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- test/tb_aud_core_top.sv
module tb_aud_core_top import aud_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int LRC_HALF = 20;
    localparam int TIMEOUT  = 100;
    localparam int K_RESET  = 0;
    localparam int K_REC    = 1;
    localparam int K_BP     = 2;

    // one row per test, -1 means the event does not happen
    typedef struct packed {
        int kind;
        int frames;
        int pause_at;
        int resume_at;
        int play_at;
        int stop;
        int rnd;
        int exp_count;
    } test_t;

    logic                  i_clk = 1'b0;
    logic                  i_rst_n;
    logic [AXI_ADDR_W-1:0] i_awaddr, i_araddr;
    logic                  i_awvalid, i_wvalid, i_bready, i_arvalid, i_rready;
    logic [AXI_DATA_W-1:0] i_wdata;
    logic [AXI_STRB_W-1:0] i_wstrb;
    logic                  i_lrc, i_adcdat;
    logic                  o_awready, o_wready, o_bvalid, o_arready, o_rvalid, o_dacdat;
    logic [1:0]            o_bresp, o_rresp;
    logic [AXI_DATA_W-1:0] o_rdata;
    logic [SAMPLE_W-1:0]   adc_q[$];
    test_t                 tests[6];
    bit                    timed_out = 1'b0;
    bit                    run_done = 1'b0;
    int                    tests_run = 0;

    aud_core_top aud_core_top_inst (.*);

    aud_checker aud_checker_inst (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_lrc(i_lrc), .i_dacdat(o_dacdat),
        .i_bvalid(o_bvalid), .i_bresp(o_bresp),
        .i_arready(o_arready), .i_rvalid(o_rvalid), .i_rready(i_rready), .i_rdata(o_rdata),
        .i_rresp(o_rresp)
    );

    always #10 i_clk = ~i_clk;

    // codec model, left sample serialized MSB first during the low half
    initial begin
        logic [SAMPLE_W-1:0] word;
        i_lrc    = 1'b1;
        i_adcdat = 1'b0;
        forever begin
            repeat (LRC_HALF) @(posedge i_clk);
            #1 i_lrc = 1'b0;
            word = (adc_q.size() != 0) ? adc_q.pop_front() : '0;
            for (int b = SAMPLE_W - 1; b >= 0; b--) begin
                i_adcdat = word[b];
                @(posedge i_clk);
                #1;
            end
            i_adcdat = 1'b0;
            repeat (LRC_HALF - SAMPLE_W) @(posedge i_clk);
            #1 i_lrc = 1'b1;
        end
    end

    task automatic timeout(input string what);
        $display("timeout: %s did not happen in %0d clocks", what, TIMEOUT);
        timed_out = 1'b1;
        wait (run_done);
    endtask

    task automatic wait_lrc(input logic level);
        logic prev;
        int   n;
        prev = i_lrc;
        n    = 0;
        do begin
            @(posedge i_clk);
            n++;
            if (prev != level && i_lrc == level) break;
            prev = i_lrc;
        end while (n < TIMEOUT);
        if (n >= TIMEOUT) timeout("lr clock edge");
        #1;
    endtask

    task automatic axi_write(input logic [AXI_ADDR_W-1:0] addr, input logic [AXI_DATA_W-1:0] data);
        int n;
        i_awaddr  = addr;
        i_wdata   = data;
        i_awvalid = 1'b1;
        i_wvalid  = 1'b1;
        n = 0;
        do begin
            @(posedge i_clk);
            n++;
        end while (!(o_awready && o_wready) && n < TIMEOUT);
        if (!(o_awready && o_wready)) timeout("write address and data acceptance");
        #1 i_awvalid = 1'b0;
        i_wvalid = 1'b0;
        n = 0;
        do begin
            @(posedge i_clk);
            n++;
        end while (!o_bvalid && n < TIMEOUT);
        if (!o_bvalid) timeout("write response");
        #1;
    endtask

    task automatic axi_read(input logic [AXI_ADDR_W-1:0] addr, input logic [AXI_DATA_W-1:0] exp,
                            input string name);
        int n;
        aud_checker_inst.expect_read(name, exp);
        i_araddr  = addr;
        i_arvalid = 1'b1;
        n = 0;
        do begin
            @(posedge i_clk);
            n++;
        end while (!o_arready && n < TIMEOUT);
        if (!o_arready) timeout("read address acceptance");
        #1 i_arvalid = 1'b0;
        n = 0;
        do begin
            @(posedge i_clk);
            n++;
        end while (!(o_rvalid && i_rready) && n < TIMEOUT);
        if (!(o_rvalid && i_rready)) timeout("read data");
        #1;
    endtask

    task automatic run_record(input test_t t);
        logic [SAMPLE_W-1:0] kept[$];
        logic [SAMPLE_W-1:0] s;
        bit                  paused;
        paused = 1'b0;
        wait_lrc(1'b1);
        axi_write(REG_CTRL, 1 << CTRL_REC_BIT);
        for (int f = 0; f < t.frames; f++) begin
            s = t.rnd != 0 ? 16'($urandom) : (16'hA500 | 16'(f));
            if (f == t.resume_at) begin
                axi_read(REG_STATUS, 32'h3, "STATUS paused");
                axi_write(REG_CTRL, 1 << CTRL_PAUSE_BIT);
                paused = 1'b0;
            end
            adc_q.push_back(s);
            if (!paused && kept.size() < MEM_DEPTH) kept.push_back(s);
            if (f == t.play_at) begin
                axi_write(REG_CTRL, 1 << CTRL_PLAY_BIT);
                axi_read(REG_STATUS, 32'h1, "STATUS play ignored");
            end
            if (f == t.pause_at) begin
                // pause lands in the middle of this frame's sample
                wait_lrc(1'b0);
                repeat (4) @(posedge i_clk);
                #1 axi_write(REG_CTRL, 1 << CTRL_PAUSE_BIT);
                paused = 1'b1;
            end
            wait_lrc(1'b1);
        end
        if (t.stop != 0) axi_write(REG_CTRL, 1 << CTRL_STOP_BIT);
        axi_read(REG_COUNT, 32'(t.exp_count), "COUNT");
        axi_read(REG_STATUS, 32'h8, "STATUS done");
        axi_write(REG_CTRL, 1 << CTRL_PLAY_BIT);
        foreach (kept[i]) aud_checker_inst.expect_sample(kept[i]);
        repeat (kept.size() + 1) wait_lrc(1'b1);
        axi_read(REG_STATUS, 32'h8, "STATUS after play");
    endtask

    task automatic run_backpressure();
        int n;
        aud_checker_inst.expect_read("COUNT held", 32'(MEM_DEPTH));
        aud_checker_inst.expect_read("STATUS second", 32'h8);
        i_rready  = 1'b0;
        i_araddr  = REG_COUNT;
        i_arvalid = 1'b1;
        @(posedge i_clk);
        #1 i_araddr = REG_STATUS;
        repeat (6) @(posedge i_clk);
        #1 i_rready = 1'b1;
        n = 0;
        do begin
            @(posedge i_clk);
            n++;
        end while (!o_arready && n < TIMEOUT);
        if (!o_arready) timeout("second read acceptance");
        #1 i_arvalid = 1'b0;
        repeat (3) @(posedge i_clk);
        #1;
    endtask

    initial begin
        i_rst_n   = 1'b0;
        i_awaddr  = '0;
        i_araddr  = '0;
        i_wdata   = '0;
        i_wstrb   = '1;
        i_awvalid = 1'b0;
        i_wvalid  = 1'b0;
        i_arvalid = 1'b0;
        i_bready  = 1'b1;
        i_rready  = 1'b1;
        void'($urandom(32'hcf59_79fa));
        tests[0] = '{K_RESET, 0, -1, -1, -1, 0, 0, 0};
        tests[1] = '{K_REC, 6, -1, -1, -1, 1, 0, 6};
        tests[2] = '{K_REC, 10, 3, 7, -1, 1, 1, 7};
        tests[3] = '{K_REC, 5, -1, -1, 2, 1, 1, 5};
        tests[4] = '{K_REC, MEM_DEPTH + 2, -1, -1, -1, 0, 1, MEM_DEPTH};
        tests[5] = '{K_BP, 0, -1, -1, -1, 0, 0, 0};
        repeat (5) @(posedge i_clk);
        #1 i_rst_n = 1'b1;
        for (int t = 0; t < 6; t++) begin
            case (tests[t].kind)
                K_RESET: begin
                    axi_read(REG_STATUS, 32'h0, "STATUS after reset");
                    axi_read(REG_COUNT, 32'h0, "COUNT after reset");
                    repeat (2) wait_lrc(1'b1);
                end
                K_REC:   run_record(tests[t]);
                default: run_backpressure();
            endcase
            aud_checker_inst.end_test(t);
            tests_run++;
        end
        run_done = 1'b1;
    end

    initial begin
        wait (timed_out || run_done);
        $display("tests run %0d, tests failed %0d, errors %0d", tests_run,
                 aud_checker_inst.tests_failed, aud_checker_inst.error_count);
        if (timed_out || aud_checker_inst.error_count != 0) begin
            $display("Result: FAILED");
        end else begin
            $display("Result: PASSED");
        end
        $finish;
    end

endmodule

//--- test/aud_checker.sv
module aud_checker import aud_pkg::*; (
    input logic                  i_clk,
    input logic                  i_rst_n,
    input logic                  i_lrc,
    input logic                  i_dacdat,
    input logic                  i_bvalid,
    input logic [1:0]            i_bresp,
    input logic                  i_arready,
    input logic                  i_rvalid,
    input logic                  i_rready,
    input logic [AXI_DATA_W-1:0] i_rdata,
    input logic [1:0]            i_rresp
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [AXI_DATA_W-1:0] rd_exp_q[$];
    string                 rd_name_q[$];
    logic [SAMPLE_W-1:0]   dac_exp_q[$];
    int                    error_count = 0;
    int                    test_errors = 0;
    int                    tests_failed = 0;
    logic                  lrc_q, capturing, rvalid_q, rready_q;
    logic [AXI_DATA_W-1:0] rdata_q, rd_exp;
    logic [SAMPLE_W-1:0]   dac_word, dac_exp;
    int                    bit_idx;
    string                 rd_name;

    task automatic expect_read(input string name, input logic [AXI_DATA_W-1:0] value);
        rd_name_q.push_back(name);
        rd_exp_q.push_back(value);
    endtask

    task automatic expect_sample(input logic [SAMPLE_W-1:0] value);
        dac_exp_q.push_back(value);
    endtask

    task automatic report_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        $display("FAILED time %0d ns: %s expected 0x%0h actual 0x%0h", $time, name, exp, act);
        error_count++;
        test_errors++;
    endtask

    task automatic report_other(input string msg);
        $display("ERROR time %0d ns: %s", $time, msg);
        error_count++;
        test_errors++;
    endtask

    task automatic end_test(input int idx);
        if (rd_exp_q.size() != 0 || dac_exp_q.size() != 0) begin
            report_other($sformatf("%0d reads and %0d samples never arrived",
                                   rd_exp_q.size(), dac_exp_q.size()));
            rd_exp_q.delete();
            rd_name_q.delete();
            dac_exp_q.delete();
        end
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("test %0d finished with %0d errors", idx, test_errors);
        test_errors = 0;
    endtask

    always @(posedge i_clk) begin
        if (!i_rst_n) begin
            lrc_q     = 1'b1;
            capturing = 1'b0;
            rvalid_q  = 1'b0;
            rready_q  = 1'b1;
            bit_idx   = 0;
        end else begin
            // bit 15 shows up one clock after the falling lr clock is seen
            if (lrc_q && !i_lrc && dac_exp_q.size() != 0) begin
                capturing = 1'b1;
                bit_idx   = 0;
            end else if (capturing) begin
                bit_idx++;
                dac_word = {dac_word[SAMPLE_W-2:0], i_dacdat};
                if (bit_idx == SAMPLE_W) begin
                    dac_exp = dac_exp_q.pop_front();
                    if (dac_word !== dac_exp) begin
                        report_value("o_dacdat sample", 32'(dac_exp), 32'(dac_word));
                    end
                    capturing = 1'b0;
                end
            end else if (i_dacdat !== 1'b0) begin
                report_other("o_dacdat is active outside a playback frame");
            end
            lrc_q = i_lrc;

            // every response is OKAY
            if (i_bvalid && i_bresp !== 2'b00) begin
                report_value("o_bresp", 32'h0, 32'(i_bresp));
            end
            if (i_rvalid && i_rresp !== 2'b00) begin
                report_value("o_rresp", 32'h0, 32'(i_rresp));
            end

            if (rvalid_q && !rready_q) begin
                if (!i_rvalid) begin
                    report_other("rvalid dropped before rready");
                end else if (i_rdata !== rdata_q) begin
                    report_value("o_rdata while held", rdata_q, i_rdata);
                end
            end
            if (i_rvalid && i_arready) begin
                report_other("arready is high while read data is pending");
            end
            if (i_rvalid && i_rready) begin
                if (rd_exp_q.size() == 0) begin
                    report_other("read response with no read outstanding");
                end else begin
                    rd_name = rd_name_q.pop_front();
                    rd_exp  = rd_exp_q.pop_front();
                    if (i_rdata !== rd_exp) begin
                        report_value({"o_rdata ", rd_name}, rd_exp, i_rdata);
                    end
                end
            end
            rvalid_q = i_rvalid;
            rready_q = i_rready;
            rdata_q  = i_rdata;
        end
    end

endmodule

//--- hw/aud_core_top.sv
module aud_core_top import aud_pkg::*; (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic [AXI_ADDR_W-1:0] i_awaddr,
    input  logic                  i_awvalid,
    output logic                  o_awready,
    input  logic [AXI_DATA_W-1:0] i_wdata,
    input  logic [AXI_STRB_W-1:0] i_wstrb,
    input  logic                  i_wvalid,
    output logic                  o_wready,
    output logic [1:0]            o_bresp,
    output logic                  o_bvalid,
    input  logic                  i_bready,
    input  logic [AXI_ADDR_W-1:0] i_araddr,
    input  logic                  i_arvalid,
    output logic                  o_arready,
    output logic [AXI_DATA_W-1:0] o_rdata,
    output logic [1:0]            o_rresp,
    output logic                  o_rvalid,
    input  logic                  i_rready,
    input  logic                  i_lrc,
    input  logic                  i_adcdat,
    output logic                  o_dacdat
);

    logic                rec_start, pause_toggle, stop, play_start;
    logic                recording, paused, playing;
    logic [COUNT_W-1:0]  count;
    logic                wr_en;
    logic [ADDR_W-1:0]   wr_addr, rd_addr;
    logic [SAMPLE_W-1:0] wr_data, rd_data;

    aud_ctrl_regs aud_ctrl_regs_inst (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_awaddr       (i_awaddr),
        .i_awvalid      (i_awvalid),
        .o_awready      (o_awready),
        .i_wdata        (i_wdata),
        .i_wstrb        (i_wstrb),
        .i_wvalid       (i_wvalid),
        .o_wready       (o_wready),
        .o_bresp        (o_bresp),
        .o_bvalid       (o_bvalid),
        .i_bready       (i_bready),
        .i_araddr       (i_araddr),
        .i_arvalid      (i_arvalid),
        .o_arready      (o_arready),
        .o_rdata        (o_rdata),
        .o_rresp        (o_rresp),
        .o_rvalid       (o_rvalid),
        .i_rready       (i_rready),
        .o_rec_start    (rec_start),
        .o_pause_toggle (pause_toggle),
        .o_stop         (stop),
        .o_play_start   (play_start),
        .i_recording    (recording),
        .i_paused       (paused),
        .i_playing      (playing),
        .i_count        (count)
    );

    aud_recorder aud_recorder_inst (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_lrc          (i_lrc),
        .i_adcdat       (i_adcdat),
        .i_rec_start    (rec_start),
        .i_pause_toggle (pause_toggle),
        .i_stop         (stop),
        .o_recording    (recording),
        .o_paused       (paused),
        .o_count        (count),
        .o_wr_en        (wr_en),
        .o_wr_addr      (wr_addr),
        .o_wr_data      (wr_data)
    );

    aud_player aud_player_inst (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_lrc        (i_lrc),
        .i_play_start (play_start),
        .i_stop       (stop),
        .i_count      (count),
        .i_rd_data    (rd_data),
        .o_rd_addr    (rd_addr),
        .o_playing    (playing),
        .o_dacdat     (o_dacdat)
    );

    sample_mem sample_mem_inst (
        .i_clk     (i_clk),
        .i_wr_en   (wr_en),
        .i_wr_addr (wr_addr),
        .i_wr_data (wr_data),
        .i_rd_addr (rd_addr),
        .o_rd_data (rd_data)
    );

endmodule

//--- hw/aud_ctrl_regs.sv
module aud_ctrl_regs import aud_pkg::*; (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic [AXI_ADDR_W-1:0] i_awaddr,
    input  logic                  i_awvalid,
    output logic                  o_awready,
    input  logic [AXI_DATA_W-1:0] i_wdata,
    input  logic [AXI_STRB_W-1:0] i_wstrb,
    input  logic                  i_wvalid,
    output logic                  o_wready,
    output logic [1:0]            o_bresp,
    output logic                  o_bvalid,
    input  logic                  i_bready,
    input  logic [AXI_ADDR_W-1:0] i_araddr,
    input  logic                  i_arvalid,
    output logic                  o_arready,
    output logic [AXI_DATA_W-1:0] o_rdata,
    output logic [1:0]            o_rresp,
    output logic                  o_rvalid,
    input  logic                  i_rready,
    output logic                  o_rec_start,
    output logic                  o_pause_toggle,
    output logic                  o_stop,
    output logic                  o_play_start,
    input  logic                  i_recording,
    input  logic                  i_paused,
    input  logic                  i_playing,
    input  logic [COUNT_W-1:0]    i_count
);

    logic                  wr_fire;
    logic                  rd_fire;
    logic                  ctrl_wr;
    logic                  bvalid_r;
    logic                  rvalid_r;
    logic [AXI_DATA_W-1:0] rdata_r;
    logic [AXI_DATA_W-1:0] rd_mux;
    logic                  rec_start_r, pause_r, stop_r, play_r;
    logic                  recording_r, playing_r;
    logic                  done_r;

    // address and data are taken together, one transfer at a time
    assign wr_fire   = i_awvalid & i_wvalid & ~bvalid_r;
    assign o_awready = i_wvalid & ~bvalid_r;
    assign o_wready  = i_awvalid & ~bvalid_r;
    assign ctrl_wr   = wr_fire & (i_awaddr == REG_CTRL) & i_wstrb[0];
    assign o_bvalid  = bvalid_r;
    assign o_bresp   = AXI_RESP_OKAY;

    assign rd_fire   = i_arvalid & ~rvalid_r;
    assign o_arready = ~rvalid_r;
    assign o_rvalid  = rvalid_r;
    assign o_rdata   = rdata_r;
    assign o_rresp   = AXI_RESP_OKAY;

    assign o_rec_start    = rec_start_r;
    assign o_pause_toggle = pause_r;
    assign o_stop         = stop_r;
    assign o_play_start   = play_r;

    always_comb begin
        rd_mux = '0;
        case (i_araddr)
            REG_STATUS: begin
                rd_mux[STAT_REC_BIT]   = i_recording;
                rd_mux[STAT_PAUSE_BIT] = i_paused;
                rd_mux[STAT_PLAY_BIT]  = i_playing;
                rd_mux[STAT_DONE_BIT]  = done_r;
            end
            REG_COUNT: rd_mux[COUNT_W-1:0] = i_count;
            default:   rd_mux = '0;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            bvalid_r    <= 1'b0;
            rvalid_r    <= 1'b0;
            rec_start_r <= 1'b0;
            pause_r     <= 1'b0;
            stop_r      <= 1'b0;
            play_r      <= 1'b0;
            recording_r <= 1'b0;
            playing_r   <= 1'b0;
            done_r      <= 1'b0;
        end else begin
            bvalid_r    <= wr_fire | (bvalid_r & ~i_bready);
            rvalid_r    <= rd_fire | (rvalid_r & ~i_rready);
            rec_start_r <= ctrl_wr & i_wdata[CTRL_REC_BIT];
            pause_r     <= ctrl_wr & i_wdata[CTRL_PAUSE_BIT];
            stop_r      <= ctrl_wr & i_wdata[CTRL_STOP_BIT];
            // no playback while the recorder owns the memory
            play_r      <= ctrl_wr & i_wdata[CTRL_PLAY_BIT] & ~i_wdata[CTRL_REC_BIT]
                           & ~i_recording;
            recording_r <= i_recording;
            playing_r   <= i_playing;
            if (rec_start_r || play_r) begin
                done_r <= 1'b0;
            end else if ((recording_r & ~i_recording) || (playing_r & ~i_playing)) begin
                done_r <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (rd_fire) begin
            rdata_r <= rd_mux;
        end
    end

endmodule

//--- hw/aud_player.sv
module aud_player import aud_pkg::*; (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_lrc,
    input  logic                i_play_start,
    input  logic                i_stop,
    input  logic [COUNT_W-1:0]  i_count,
    input  logic [SAMPLE_W-1:0] i_rd_data,
    output logic [ADDR_W-1:0]   o_rd_addr,
    output logic                o_playing,
    output logic                o_dacdat
);

    typedef enum logic [1:0] {S_IDLE, S_WAIT, S_SHIFT} state_t;

    state_t                  state_r, state_w;
    logic                    lrc_r;
    logic                    lrc_fall;
    logic [COUNT_W-1:0]      idx_r, idx_w;
    logic [SAMPLE_CNT_W-1:0] bit_r, bit_w;
    logic [SAMPLE_W-1:0]     shift_r, shift_w;
    logic                    dac_r, dac_w;

    assign lrc_fall  = lrc_r & ~i_lrc;
    // idle holds address 0 so the first sample is already on i_rd_data
    assign o_rd_addr = idx_r[ADDR_W-1:0];
    assign o_playing = (state_r != S_IDLE);
    assign o_dacdat  = dac_r;

    always_comb begin
        state_w = state_r;
        idx_w   = idx_r;
        bit_w   = bit_r;
        shift_w = shift_r;
        dac_w   = 1'b0;
        case (state_r)
            S_IDLE: begin
                idx_w = '0;
                if (i_play_start && i_count != '0) begin
                    state_w = S_WAIT;
                end
            end
            S_WAIT: begin
                if (lrc_fall) begin
                    dac_w   = i_rd_data[SAMPLE_W-1];
                    shift_w = {i_rd_data[SAMPLE_W-2:0], 1'b0};
                    bit_w   = SAMPLE_CNT_W'(1);
                    // prefetch the next sample during this frame
                    idx_w   = idx_r + COUNT_W'(1);
                    state_w = S_SHIFT;
                end
            end
            S_SHIFT: begin
                if (bit_r == SAMPLE_CNT_W'(SAMPLE_W)) begin
                    if (idx_r == i_count) begin
                        state_w = S_IDLE;
                        idx_w   = '0;
                    end else begin
                        state_w = S_WAIT;
                    end
                end else begin
                    dac_w   = shift_r[SAMPLE_W-1];
                    shift_w = {shift_r[SAMPLE_W-2:0], 1'b0};
                    bit_w   = bit_r + SAMPLE_CNT_W'(1);
                end
            end
            default: state_w = S_IDLE;
        endcase
        if (i_stop && state_r != S_IDLE) begin
            state_w = S_IDLE;
            idx_w   = '0;
            dac_w   = 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state_r <= S_IDLE;
            lrc_r   <= 1'b0;
            idx_r   <= '0;
            bit_r   <= '0;
            dac_r   <= 1'b0;
        end else begin
            state_r <= state_w;
            lrc_r   <= i_lrc;
            idx_r   <= idx_w;
            bit_r   <= bit_w;
            dac_r   <= dac_w;
        end
    end

    always_ff @(posedge i_clk) begin
        shift_r <= shift_w;
    end

endmodule

//--- hw/aud_recorder.sv
module aud_recorder import aud_pkg::*; (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_lrc,
    input  logic                i_adcdat,
    input  logic                i_rec_start,
    input  logic                i_pause_toggle,
    input  logic                i_stop,
    output logic                o_recording,
    output logic                o_paused,
    output logic [COUNT_W-1:0]  o_count,
    output logic                o_wr_en,
    output logic [ADDR_W-1:0]   o_wr_addr,
    output logic [SAMPLE_W-1:0] o_wr_data
);

    typedef enum logic [1:0] {S_IDLE, S_WAIT, S_CAPTURE, S_PAUSED} state_t;

    state_t                  state_r, state_w;
    logic                    lrc_r;
    logic                    lrc_fall;
    logic [SAMPLE_CNT_W-1:0] bit_r, bit_w;
    logic [SAMPLE_W-1:0]     sample_r, sample_w;
    logic                    pend_r, pend_w;
    logic                    wr_en_r, wr_en_w;
    logic [COUNT_W-1:0]      count_r, count_w;

    // first clock of the low (left) half
    assign lrc_fall = lrc_r & ~i_lrc;

    assign o_recording = (state_r != S_IDLE);
    assign o_paused    = (state_r == S_PAUSED) | pend_r;
    assign o_count     = count_r;
    assign o_wr_en     = wr_en_r;
    assign o_wr_addr   = count_r[ADDR_W-1:0];
    assign o_wr_data   = sample_r;

    always_comb begin
        state_w  = state_r;
        bit_w    = bit_r;
        sample_w = sample_r;
        pend_w   = pend_r;
        wr_en_w  = 1'b0;
        // count advances on the edge that writes the sample
        count_w  = count_r + COUNT_W'(wr_en_r);
        case (state_r)
            S_IDLE: begin
                pend_w = 1'b0;
                if (i_rec_start) begin
                    state_w = S_WAIT;
                    count_w = '0;
                end
            end
            S_WAIT: begin
                if (i_pause_toggle) begin
                    state_w = S_PAUSED;
                end else if (lrc_fall) begin
                    // this edge takes the msb
                    sample_w = {sample_r[SAMPLE_W-2:0], i_adcdat};
                    bit_w    = SAMPLE_CNT_W'(1);
                    state_w  = S_CAPTURE;
                end
            end
            S_CAPTURE: begin
                sample_w = {sample_r[SAMPLE_W-2:0], i_adcdat};
                if (bit_r == SAMPLE_CNT_W'(SAMPLE_W - 1)) begin
                    wr_en_w = 1'b1;
                    pend_w  = 1'b0;
                    state_w = (pend_r ^ i_pause_toggle) ? S_PAUSED : S_WAIT;
                end else begin
                    bit_w = bit_r + SAMPLE_CNT_W'(1);
                    if (i_pause_toggle) begin
                        pend_w = ~pend_r;
                    end
                end
            end
            S_PAUSED: begin
                if (i_pause_toggle) begin
                    state_w = S_WAIT;
                end
            end
            default: state_w = S_IDLE;
        endcase
        // stop or last free slot being written, a partial sample is dropped
        if (state_r != S_IDLE) begin
            if (i_stop || (wr_en_r && count_r == COUNT_W'(MEM_DEPTH - 1))) begin
                state_w = S_IDLE;
                pend_w  = 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state_r <= S_IDLE;
            lrc_r   <= 1'b0;
            bit_r   <= '0;
            pend_r  <= 1'b0;
            wr_en_r <= 1'b0;
            count_r <= '0;
        end else begin
            state_r <= state_w;
            lrc_r   <= i_lrc;
            bit_r   <= bit_w;
            pend_r  <= pend_w;
            wr_en_r <= wr_en_w;
            count_r <= count_w;
        end
    end

    always_ff @(posedge i_clk) begin
        sample_r <= sample_w;
    end

endmodule

//--- hw/sample_mem.sv
module sample_mem import aud_pkg::*; (
    input  logic                i_clk,
    input  logic                i_wr_en,
    input  logic [ADDR_W-1:0]   i_wr_addr,
    input  logic [SAMPLE_W-1:0] i_wr_data,
    input  logic [ADDR_W-1:0]   i_rd_addr,
    output logic [SAMPLE_W-1:0] o_rd_data
);

    logic [SAMPLE_W-1:0] mem [MEM_DEPTH];

    always_ff @(posedge i_clk) begin
        if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_data;
        end
    end

    // registered read, data follows the address by one clock
    always_ff @(posedge i_clk) begin
        o_rd_data <= mem[i_rd_addr];
    end

endmodule

//--- hw/aud_pkg.sv
package aud_pkg;

    // sample format
    localparam int SAMPLE_W     = 16;
    localparam int SAMPLE_CNT_W = $clog2(SAMPLE_W) + 1;

    // sample memory, recording stops once it holds MEM_DEPTH samples
    localparam int MEM_DEPTH = 256;
    localparam int ADDR_W    = $clog2(MEM_DEPTH);
    localparam int COUNT_W   = ADDR_W + 1;

    // axi4-lite bus
    localparam int         AXI_ADDR_W    = 4;
    localparam int         AXI_DATA_W    = 32;
    localparam int         AXI_STRB_W    = AXI_DATA_W / 8;
    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

    // register byte offsets
    localparam logic [AXI_ADDR_W-1:0] REG_CTRL   = 4'h0;
    localparam logic [AXI_ADDR_W-1:0] REG_STATUS = 4'h4;
    localparam logic [AXI_ADDR_W-1:0] REG_COUNT  = 4'h8;

    // command bits in REG_CTRL
    localparam int CTRL_REC_BIT   = 0;
    localparam int CTRL_PAUSE_BIT = 1;
    localparam int CTRL_STOP_BIT  = 2;
    localparam int CTRL_PLAY_BIT  = 3;

    // flag bits in REG_STATUS
    localparam int STAT_REC_BIT   = 0;
    localparam int STAT_PAUSE_BIT = 1;
    localparam int STAT_PLAY_BIT  = 2;
    localparam int STAT_DONE_BIT  = 3;

endpackage
